// File: hdl/soc_periph_pkg.sv
// Shared widths, bus request/response structs and slot address map
// Register word offsets, interrupt numbering and router state encoding
`default_nettype none

package soc_periph_pkg;

    // Bus widths
    typedef logic [15:0] bus_addr_t;   // [15:12] slot, [11:2] word
    typedef logic [31:0] bus_data_t;
    typedef logic [9:0]  word_offset_t;
    typedef logic [3:0]  bus_slot_t;
    typedef logic [63:0] mtime_t;

    typedef struct packed {
        bus_addr_t addr;
        logic      we;
        bus_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        bus_data_t rdata;
        logic      err;
    } bus_rsp_t;

    // Slot map, anything else is unmapped
    localparam bus_slot_t SLOT_GPIO  = 4'd0;
    localparam bus_slot_t SLOT_TIMER = 4'd1;
    localparam bus_slot_t SLOT_IRQ   = 4'd2;

    localparam bus_data_t UNMAPPED_DATA = 32'hdead_beef;

    // GPIO
    localparam int SOC_GPIO_WIDTH = 8;
    typedef logic [SOC_GPIO_WIDTH-1:0] gpio_vec_t;

    // Interrupt sources, id 0 is reserved for "none"
    localparam int SOC_IRQ_TOTAL = 16;
    typedef logic [SOC_IRQ_TOTAL-1:0] irq_vec_t;
    typedef logic [3:0]               irq_id_t;

    localparam int IRQ_GPIO_BASE = 1;  // Pin n on source 1+n
    localparam int IRQ_MSIP      = 12;

    // GPIO register words
    localparam word_offset_t GPIO_OUT = 10'd0;
    localparam word_offset_t GPIO_DIR = 10'd1;
    localparam word_offset_t GPIO_IN  = 10'd2;
    localparam word_offset_t GPIO_IE  = 10'd3;

    // Timer register words
    localparam word_offset_t TMR_MTIME_LO = 10'd0;
    localparam word_offset_t TMR_MTIME_HI = 10'd1;
    localparam word_offset_t TMR_CMP_LO   = 10'd2;
    localparam word_offset_t TMR_CMP_HI   = 10'd3;
    localparam word_offset_t TMR_MSIP     = 10'd4;

    // Interrupt controller register words
    localparam word_offset_t IRQ_PENDING = 10'd0;
    localparam word_offset_t IRQ_ENABLE  = 10'd1;
    localparam word_offset_t IRQ_CLAIM   = 10'd2;

    typedef enum logic {
        RT_IDLE,
        RT_RESP
    } router_state_t;

endpackage : soc_periph_pkg

`default_nettype wire

// File: hdl/periph_router.sv
// Peripheral router: accepts one request at a time, decodes the slot,
// strobes the selected slave and holds the registered response
`timescale 1ns/1ps
`default_nettype none

module periph_router
    import soc_periph_pkg::*;
(
    input  logic         i_sys_clk,
    input  logic         i_reset,
    // Request channel
    input  logic         i_req_valid,
    output logic         o_req_ready,
    input  bus_req_t     i_req,
    // Response channel
    output logic         o_rsp_valid,
    input  logic         i_rsp_ready,
    output bus_rsp_t     o_rsp,
    // Broadcast to slaves
    output word_offset_t o_offset,
    output bus_data_t    o_wdata,
    output logic         o_gpio_we,
    output logic         o_gpio_re,
    output logic         o_tmr_we,
    output logic         o_tmr_re,
    output logic         o_irq_we,
    output logic         o_irq_re,
    input  bus_data_t    i_gpio_rdata,
    input  bus_data_t    i_tmr_rdata,
    input  bus_data_t    i_irq_rdata
);

    router_state_t state;
    logic          accept;
    bus_slot_t     slot;
    logic          hit_gpio;
    logic          hit_tmr;
    logic          hit_irq;
    bus_rsp_t      next_rsp;

    assign o_req_ready = (state == RT_IDLE);
    assign o_rsp_valid = (state == RT_RESP);
    assign accept      = i_req_valid & o_req_ready;

    assign slot     = i_req.addr[15:12];
    assign hit_gpio = (slot == SLOT_GPIO);
    assign hit_tmr  = (slot == SLOT_TIMER);
    assign hit_irq  = (slot == SLOT_IRQ);

    assign o_offset = i_req.addr[11:2];
    assign o_wdata  = i_req.wdata;

    // One-cycle strobes, only on the transfer edge
    assign o_gpio_we = accept & hit_gpio & i_req.we;
    assign o_gpio_re = accept & hit_gpio & ~i_req.we;
    assign o_tmr_we  = accept & hit_tmr & i_req.we;
    assign o_tmr_re  = accept & hit_tmr & ~i_req.we;
    assign o_irq_we  = accept & hit_irq & i_req.we;
    assign o_irq_re  = accept & hit_irq & ~i_req.we;

    // Response mux
    always_comb
    begin
        next_rsp.rdata = UNMAPPED_DATA;
        next_rsp.err   = 1'b1;
        if (i_req.we)
        begin
            next_rsp.rdata = '0;   // Writes always complete cleanly
            next_rsp.err   = 1'b0;
        end
        else if (hit_gpio)
        begin
            next_rsp.rdata = i_gpio_rdata;
            next_rsp.err   = 1'b0;
        end
        else if (hit_tmr)
        begin
            next_rsp.rdata = i_tmr_rdata;
            next_rsp.err   = 1'b0;
        end
        else if (hit_irq)
        begin
            next_rsp.rdata = i_irq_rdata;
            next_rsp.err   = 1'b0;
        end
    end

    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
            state <= RT_IDLE;
        else
        begin
            case (state)
                RT_IDLE: if (accept) state <= RT_RESP;
                RT_RESP: if (i_rsp_ready) state <= RT_IDLE;   // Response taken
                default: state <= RT_IDLE;
            endcase
        end
    end

    // Held until the master takes it
    always_ff @(posedge i_sys_clk)
    begin
        if (accept)
            o_rsp <= next_rsp;
    end

endmodule : periph_router

`default_nettype wire

// File: hdl/gpio_regs.sv
// GPIO register block: output, direction and interrupt enable registers
// plus a two-flop input synchronizer
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
    import soc_periph_pkg::*;
(
    input  logic         i_sys_clk,
    input  logic         i_reset,
    input  word_offset_t i_offset,
    input  bus_data_t    i_wdata,
    input  logic         i_we,
    input  logic         i_re,         // Reads have no side effects here
    output bus_data_t    o_rdata,
    input  gpio_vec_t    i_gpio,
    output gpio_vec_t    o_gpio,
    output gpio_vec_t    o_gpio_dir,
    output gpio_vec_t    o_irq
);

    gpio_vec_t out_r;
    gpio_vec_t dir_r;
    gpio_vec_t ie_r;
    gpio_vec_t in_meta;
    gpio_vec_t in_sync;

    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
        begin
            out_r <= '0;
            dir_r <= '0;
            ie_r  <= '0;
        end
        else if (i_we)
        begin
            case (i_offset)
                GPIO_OUT: out_r <= i_wdata[SOC_GPIO_WIDTH-1:0];
                GPIO_DIR: dir_r <= i_wdata[SOC_GPIO_WIDTH-1:0];
                GPIO_IE:  ie_r  <= i_wdata[SOC_GPIO_WIDTH-1:0];
                default: ;   // GPIO_IN is read only
            endcase
        end
    end

    // Pins are asynchronous to the bus clock
    always_ff @(posedge i_sys_clk)
    begin
        in_meta <= i_gpio;
        in_sync <= in_meta;
    end

    always_comb
    begin
        case (i_offset)
            GPIO_OUT: o_rdata = bus_data_t'(out_r);
            GPIO_DIR: o_rdata = bus_data_t'(dir_r);
            GPIO_IN:  o_rdata = bus_data_t'(in_sync);
            GPIO_IE:  o_rdata = bus_data_t'(ie_r);
            default:  o_rdata = '0;
        endcase
    end

    assign o_gpio     = out_r;
    assign o_gpio_dir = dir_r;
    assign o_irq      = in_sync & ie_r;   // Level, edge detect is in irq_ctrl

endmodule : gpio_regs

`default_nettype wire

// File: hdl/mtimer.sv
// Machine timer: free-running 64-bit mtime, mtimecmp and msip
// Timer interrupt while mtime >= mtimecmp
`timescale 1ns/1ps
`default_nettype none

module mtimer
    import soc_periph_pkg::*;
(
    input  logic         i_sys_clk,
    input  logic         i_reset,
    input  word_offset_t i_offset,
    input  bus_data_t    i_wdata,
    input  logic         i_we,
    output bus_data_t    o_rdata,
    output logic         o_mtip,
    output logic         o_msip
);

    mtime_t mtime;
    mtime_t mtimecmp;
    logic   msip_r;

    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
        begin
            mtime    <= '0;
            mtimecmp <= '1;   // Never reached, so no timer irq out of reset
            msip_r   <= 1'b0;
        end
        else
        begin
            mtime <= mtime + 64'd1;
            if (i_we)
            begin
                case (i_offset)
                    TMR_CMP_LO: mtimecmp[31:0]  <= i_wdata;
                    TMR_CMP_HI: mtimecmp[63:32] <= i_wdata;
                    TMR_MSIP:   msip_r          <= i_wdata[0];
                    default: ;   // mtime is read only
                endcase
            end
        end
    end

    always_comb
    begin
        case (i_offset)
            TMR_MTIME_LO: o_rdata = mtime[31:0];
            TMR_MTIME_HI: o_rdata = mtime[63:32];
            TMR_CMP_LO:   o_rdata = mtimecmp[31:0];
            TMR_CMP_HI:   o_rdata = mtimecmp[63:32];
            TMR_MSIP:     o_rdata = bus_data_t'(msip_r);
            default:      o_rdata = '0;
        endcase
    end

    assign o_mtip = (mtime >= mtimecmp);
    assign o_msip = msip_r;

endmodule : mtimer

`default_nettype wire

// File: hdl/irq_ctrl.sv
// Interrupt controller, one machine context
// Edge-captured pending bits, enable mask, claim by read, meip output
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
    import soc_periph_pkg::*;
(
    input  logic         i_sys_clk,
    input  logic         i_reset,
    input  word_offset_t i_offset,
    input  bus_data_t    i_wdata,
    input  logic         i_we,
    input  logic         i_re,
    output bus_data_t    o_rdata,
    input  irq_vec_t     i_sources,
    output logic         o_meip
);

    irq_vec_t src_q;       // Sampled sources
    irq_vec_t src_prev;    // Previous sample for edge detect
    irq_vec_t rise;
    irq_vec_t pending;
    irq_vec_t enable;
    irq_vec_t active;
    irq_vec_t claim_mask;
    irq_id_t  claim_id;

    // Source 0 means "none" and never pends
    assign rise   = src_q & ~src_prev & ~irq_vec_t'(1);
    assign active = pending & enable;
    assign o_meip = |active;

    // Lowest numbered active source wins
    always_comb
    begin
        claim_id = '0;
        for (int i = SOC_IRQ_TOTAL - 1; i >= 1; i--)
        begin
            if (active[i])
                claim_id = irq_id_t'(i);
        end
    end

    always_comb
    begin
        claim_mask = '0;
        if (i_re && (i_offset == IRQ_CLAIM))
            claim_mask[claim_id] = 1'b1;   // Bit 0 is harmless, never pending
    end

    always_ff @(posedge i_sys_clk)
    begin
        if (i_reset)
        begin
            src_q    <= '0;
            src_prev <= '0;
            pending  <= '0;
            enable   <= '0;
        end
        else
        begin
            src_q    <= i_sources;
            src_prev <= src_q;
            pending  <= (pending & ~claim_mask) | rise;   // New edge beats claim
            if (i_we && (i_offset == IRQ_ENABLE))
                enable <= i_wdata[SOC_IRQ_TOTAL-1:0];
        end
    end

    always_comb
    begin
        case (i_offset)
            IRQ_PENDING: o_rdata = bus_data_t'(pending);
            IRQ_ENABLE:  o_rdata = bus_data_t'(enable);
            IRQ_CLAIM:   o_rdata = bus_data_t'(claim_id);
            default:     o_rdata = '0;
        endcase
    end

endmodule : irq_ctrl

`default_nettype wire

// File: hdl/periph_soc.sv
// Peripheral subsystem top with router, GPIO, machine timer and interrupt controller
// and the mapping of interrupt lines onto controller sources
`timescale 1ns/1ps
`default_nettype none

module periph_soc
    import soc_periph_pkg::*;
(
    input  logic      i_sys_clk,     // System/bus clock
    input  logic      i_reset,
    // Register bus
    input  logic      i_req_valid,
    output logic      o_req_ready,
    input  bus_req_t  i_req,
    output logic      o_rsp_valid,
    input  logic      i_rsp_ready,
    output bus_rsp_t  o_rsp,
    // GPIO pins
    input  gpio_vec_t i_gpio,
    output gpio_vec_t o_gpio,
    output gpio_vec_t o_gpio_dir,
    // Interrupts to the hart
    output logic      o_mtip,
    output logic      o_msip,
    output logic      o_meip
);

    word_offset_t w_offset;
    bus_data_t    wb_wdata;
    logic         w_gpio_we;
    logic         w_tmr_we;
    logic         w_irq_we;
    logic         w_irq_re;
    bus_data_t    wb_gpio_rdata;
    bus_data_t    wb_tmr_rdata;
    bus_data_t    wb_irq_rdata;
    gpio_vec_t    wb_irq_gpio;
    logic         w_clint_msip;
    irq_vec_t     wb_ext_irqs;

    periph_router router0 (
        .i_sys_clk(i_sys_clk),
        .i_reset(i_reset),
        .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready),
        .i_req(i_req),
        .o_rsp_valid(o_rsp_valid),
        .i_rsp_ready(i_rsp_ready),
        .o_rsp(o_rsp),
        .o_offset(w_offset),
        .o_wdata(wb_wdata),
        .o_gpio_we(w_gpio_we),
        .o_gpio_re(),                // GPIO reads have no side effects
        .o_tmr_we(w_tmr_we),
        .o_tmr_re(),                 // Timer reads have no side effects
        .o_irq_we(w_irq_we),
        .o_irq_re(w_irq_re),
        .i_gpio_rdata(wb_gpio_rdata),
        .i_tmr_rdata(wb_tmr_rdata),
        .i_irq_rdata(wb_irq_rdata)
    );

    gpio_regs gpio0 (
        .i_sys_clk(i_sys_clk),
        .i_reset(i_reset),
        .i_offset(w_offset),
        .i_wdata(wb_wdata),
        .i_we(w_gpio_we),
        .i_re(),
        .o_rdata(wb_gpio_rdata),
        .i_gpio(i_gpio),
        .o_gpio(o_gpio),
        .o_gpio_dir(o_gpio_dir),
        .o_irq(wb_irq_gpio)
    );

    mtimer clint0 (
        .i_sys_clk(i_sys_clk),
        .i_reset(i_reset),
        .i_offset(w_offset),
        .i_wdata(wb_wdata),
        .i_we(w_tmr_we),
        .o_rdata(wb_tmr_rdata),
        .o_mtip(o_mtip),
        .o_msip(w_clint_msip)
    );

    irq_ctrl plic0 (
        .i_sys_clk(i_sys_clk),
        .i_reset(i_reset),
        .i_offset(w_offset),
        .i_wdata(wb_wdata),
        .i_we(w_irq_we),
        .i_re(w_irq_re),
        .o_rdata(wb_irq_rdata),
        .i_sources(wb_ext_irqs),
        .o_meip(o_meip)
    );

    always_comb
    begin: comb_proc
        irq_vec_t vb_ext_irqs;

        vb_ext_irqs = '0;   // Unused sources tied low
        vb_ext_irqs[IRQ_GPIO_BASE +: SOC_GPIO_WIDTH] = wb_irq_gpio;
        // Software irq also visible to the controller
        vb_ext_irqs[IRQ_MSIP] = w_clint_msip;
        wb_ext_irqs = vb_ext_irqs;

        o_msip = w_clint_msip;
    end: comb_proc

endmodule : periph_soc

`default_nettype wire

// File: verification/periph_soc_chk.sv
// Bound checks on the router bus handshake and its reset state
`timescale 1ns/1ps
`default_nettype none

module periph_soc_chk
    import soc_periph_pkg::*;
(
    input wire logic     i_sys_clk,
    input wire logic     i_reset,
    input wire logic     o_req_ready,
    input wire logic     o_rsp_valid,
    input wire logic     i_rsp_ready,
    input wire bus_rsp_t o_rsp
);

    // Held response must not move under back-pressure
    rsp_stable_a: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        (o_rsp_valid && !i_rsp_ready) |=> $stable(o_rsp))
        else $error("response changed while stalled");

    one_in_flight_a: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        !(o_req_ready && o_rsp_valid))
        else $error("request ready while a response is pending");

    rsp_reset_a: assert property (@(posedge i_sys_clk)
        i_reset |=> !o_rsp_valid)
        else $error("response valid after reset");

endmodule : periph_soc_chk

bind periph_router periph_soc_chk chk0 (
    .i_sys_clk(i_sys_clk),
    .i_reset(i_reset),
    .o_req_ready(o_req_ready),
    .o_rsp_valid(o_rsp_valid),
    .i_rsp_ready(i_rsp_ready),
    .o_rsp(o_rsp)
);

`default_nettype wire

// File: verification/tb_periph_soc.sv
// Testbench for periph_soc with clock, reset and a bus driver with response stalls
// Shadow register model, response compare process and directed interrupt tests
`timescale 1ns/1ps
`default_nettype none

module tb_periph_soc
    import soc_periph_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;

    typedef struct packed {
        bus_rsp_t rsp;
        logic     chk_data;   // Zero when rdata is checked by the caller
    } exp_rsp_t;

    logic      sys_clk;
    logic      reset;
    logic      req_valid;
    bus_req_t  req;
    logic      rsp_ready;
    gpio_vec_t gpio_in;
    logic      req_ready;
    logic      rsp_valid;
    bus_rsp_t  rsp;
    gpio_vec_t gpio_out;
    gpio_vec_t gpio_dir;
    logic      mtip;
    logic      msip;
    logic      meip;

    exp_rsp_t  exp_q[$];
    int        cyc;

    // Shadow registers
    gpio_vec_t sh_out;
    gpio_vec_t sh_dir;
    gpio_vec_t sh_ie;
    mtime_t    sh_cmp;
    logic      sh_msip;
    irq_vec_t  sh_pending;
    irq_vec_t  sh_irq_en;

    periph_soc uut (
        .i_sys_clk(sys_clk),
        .i_reset(reset),
        .i_req_valid(req_valid),
        .o_req_ready(req_ready),
        .i_req(req),
        .o_rsp_valid(rsp_valid),
        .i_rsp_ready(rsp_ready),
        .o_rsp(rsp),
        .i_gpio(gpio_in),
        .o_gpio(gpio_out),
        .o_gpio_dir(gpio_dir),
        .o_mtip(mtip),
        .o_msip(msip),
        .o_meip(meip)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Expected read data from the register rules
    function automatic bus_rsp_t expected_read(input bus_slot_t slot, input word_offset_t off);
        bus_rsp_t r;

        r.rdata = '0;
        r.err   = 1'b0;
        case (slot)
            SLOT_GPIO:
                case (off)
                    GPIO_OUT: r.rdata = {24'd0, sh_out};
                    GPIO_DIR: r.rdata = {24'd0, sh_dir};
                    GPIO_IE:  r.rdata = {24'd0, sh_ie};
                    default:  r.rdata = '0;
                endcase
            SLOT_TIMER:
                case (off)
                    TMR_CMP_LO: r.rdata = sh_cmp[31:0];
                    TMR_CMP_HI: r.rdata = sh_cmp[63:32];
                    TMR_MSIP:   r.rdata = {31'd0, sh_msip};
                    default:    r.rdata = '0;
                endcase
            SLOT_IRQ:
                case (off)
                    IRQ_PENDING: r.rdata = {16'd0, sh_pending};
                    IRQ_ENABLE:  r.rdata = {16'd0, sh_irq_en};
                    default:     r.rdata = '0;
                endcase
            default:
            begin
                r.rdata = UNMAPPED_DATA;
                r.err   = 1'b1;
            end
        endcase
        return r;
    endfunction

    // Compare every response as it transfers
    always @(negedge sys_clk)
    begin
        exp_rsp_t e;

        if (!reset && rsp_valid && rsp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("A response arrived with no request outstanding");
                $display("Regression failed");
                $fatal(1);
            end
            e = exp_q.pop_front();
            check_eq(rsp.err, e.rsp.err, "response err");
            if (e.chk_data)
                check_eq(rsp.rdata, e.rsp.rdata, "response rdata");
        end
    end

    task automatic bus_xfer(input bus_slot_t slot, input word_offset_t off, input logic we,
                            input bus_data_t wdata, output bus_rsp_t got, output int acc_cyc);
        bus_rsp_t first;

        @(posedge sys_clk);
        req_valid <= 1'b1;
        req       <= '{addr: {slot, off, 2'b00}, we: we, wdata: wdata};
        @(negedge sys_clk);
        while (!req_ready)
            @(negedge sys_clk);
        acc_cyc = cyc;
        @(posedge sys_clk);   // Transfer edge
        req_valid <= 1'b0;
        rsp_ready <= ($urandom_range(0, 2) != 0);
        @(negedge sys_clk);
        first = rsp;
        while (!(rsp_valid && rsp_ready))
        begin
            check_eq(req_ready, 1'b0, "request ready during a response stall");
            @(posedge sys_clk);
            rsp_ready <= ($urandom_range(0, 2) != 0);
            @(negedge sys_clk);
        end
        got = rsp;
        check_eq(got, first, "held response");
        @(posedge sys_clk);
        rsp_ready <= 1'b0;
        @(negedge sys_clk);   // Outputs settled for the caller
    endtask

    task automatic bus_write(input bus_slot_t slot, input word_offset_t off, input bus_data_t d);
        bus_rsp_t got;
        int       acc;

        exp_q.push_back('{rsp: '{rdata: '0, err: 1'b0}, chk_data: 1'b1});
        bus_xfer(slot, off, 1'b1, d, got, acc);
        if (slot == SLOT_GPIO && off == GPIO_OUT) sh_out = d[7:0];
        if (slot == SLOT_GPIO && off == GPIO_DIR) sh_dir = d[7:0];
        if (slot == SLOT_GPIO && off == GPIO_IE) sh_ie = d[7:0];
        if (slot == SLOT_TIMER && off == TMR_CMP_LO) sh_cmp[31:0] = d;
        if (slot == SLOT_TIMER && off == TMR_CMP_HI) sh_cmp[63:32] = d;
        if (slot == SLOT_TIMER && off == TMR_MSIP) sh_msip = d[0];
        if (slot == SLOT_IRQ && off == IRQ_ENABLE) sh_irq_en = d[15:0];
    endtask

    // chk selects whether the compare process checks rdata
    task automatic bus_read(input bus_slot_t slot, input word_offset_t off, input bus_rsp_t exp,
                            input logic chk, output bus_data_t d, output int acc);
        bus_rsp_t got;

        exp_q.push_back('{rsp: exp, chk_data: chk});
        bus_xfer(slot, off, 1'b0, '0, got, acc);
        d = got.rdata;
    endtask

    // Polls meip when sel_meip is set, mtip otherwise
    task automatic wait_irq_high(input logic sel_meip, input int limit, input string what);
        int n;

        n = 0;
        @(negedge sys_clk);
        while (!(sel_meip ? meip : mtip))
        begin
            n++;
            if (n > limit)
            begin
                $display("Gave up waiting for %s to go high", what);
                $display("Regression failed");
                $fatal(1);
            end
            @(negedge sys_clk);
        end
    endtask

    initial
    begin
        bus_data_t    d;
        bus_data_t    t0;
        int           a0;
        int           a1;
        word_offset_t off;
        bus_rsp_t     none;

        void'($urandom(32'h1b61));
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        gpio_in = '0;
        cyc = 0;
        sh_out = '0;
        sh_dir = '0;
        sh_ie = '0;
        sh_cmp = '1;
        sh_msip = 1'b0;
        sh_pending = '0;
        sh_irq_en = '0;
        none = '{rdata: '0, err: 1'b0};
        repeat (3) @(posedge sys_clk);
        reset <= 1'b0;
        @(negedge sys_clk);
        check_eq({gpio_out, gpio_dir, mtip, msip, meip}, '0, "outputs after reset");
        check_eq({req_ready, rsp_valid}, 2'b10, "handshake after reset");

        // Random traffic to the GPIO registers
        for (int i = 0; i < 60; i++)
        begin
            case ($urandom_range(0, 2))
                0: off = GPIO_OUT;
                1: off = GPIO_DIR;
                default: off = GPIO_IE;
            endcase
            if ($urandom_range(0, 1) == 1)
            begin
                bus_write(SLOT_GPIO, off, $urandom);
                check_eq({gpio_out, gpio_dir}, {sh_out, sh_dir}, "gpio pins");
            end
            else
                bus_read(SLOT_GPIO, off, expected_read(SLOT_GPIO, off), 1'b1, d, a0);
        end

        // Unmapped slots report err on reads while writes complete
        for (int s = 3; s < 16; s++)
            bus_read(bus_slot_t'(s), word_offset_t'($urandom_range(0, 1023)),
                     expected_read(bus_slot_t'(s), '0), 1'b1, d, a0);
        bus_write(4'd9, 10'd5, 32'h1234_5678);

        // mtime advances once per edge
        bus_read(SLOT_TIMER, TMR_MTIME_HI, none, 1'b1, d, a0);
        bus_read(SLOT_TIMER, TMR_MTIME_LO, none, 1'b0, t0, a0);
        bus_read(SLOT_TIMER, TMR_MTIME_LO, none, 1'b0, d, a1);
        check_eq(d - t0, a1 - a0, "mtime delta");

        // Timer compare
        bus_write(SLOT_TIMER, TMR_CMP_LO, d + 32'd200);
        bus_write(SLOT_TIMER, TMR_CMP_HI, 32'd0);
        check_eq(mtip, 1'b0, "mtip right after compare write");
        bus_read(SLOT_TIMER, TMR_CMP_LO, expected_read(SLOT_TIMER, TMR_CMP_LO), 1'b1, d, a0);
        wait_irq_high(1'b0, 400, "mtip");
        bus_write(SLOT_TIMER, TMR_CMP_HI, 32'hffff_ffff);
        check_eq(mtip, 1'b0, "mtip after compare restore");

        // GPIO interrupts through the controller with pins 0, 1 and 3 enabled
        bus_write(SLOT_GPIO, GPIO_IE, 32'h0b);
        bus_write(SLOT_IRQ, IRQ_ENABLE, 32'h0016);
        @(posedge sys_clk);
        gpio_in <= 8'h0f;
        wait_irq_high(1'b1, 20, "meip from gpio");
        repeat (4) @(negedge sys_clk);
        sh_pending = 16'h0016;
        bus_read(SLOT_IRQ, IRQ_PENDING, expected_read(SLOT_IRQ, IRQ_PENDING), 1'b1, d, a0);
        bus_read(SLOT_IRQ, IRQ_CLAIM, '{rdata: 32'd1, err: 1'b0}, 1'b1, d, a0);
        bus_read(SLOT_IRQ, IRQ_CLAIM, '{rdata: 32'd2, err: 1'b0}, 1'b1, d, a0);
        bus_read(SLOT_IRQ, IRQ_CLAIM, '{rdata: 32'd4, err: 1'b0}, 1'b1, d, a0);
        bus_read(SLOT_IRQ, IRQ_CLAIM, none, 1'b1, d, a0);
        sh_pending = '0;
        check_eq(meip, 1'b0, "meip after claims");

        // Software interrupt on source 12
        bus_write(SLOT_IRQ, IRQ_ENABLE, 32'h1 << IRQ_MSIP);
        bus_write(SLOT_TIMER, TMR_MSIP, 32'h1);
        check_eq(msip, 1'b1, "msip after write");
        wait_irq_high(1'b1, 20, "meip from msip");
        bus_read(SLOT_IRQ, IRQ_CLAIM, '{rdata: IRQ_MSIP, err: 1'b0}, 1'b1, d, a0);
        bus_read(SLOT_TIMER, TMR_MSIP, expected_read(SLOT_TIMER, TMR_MSIP), 1'b1, d, a0);
        bus_write(SLOT_TIMER, TMR_MSIP, 32'h0);

        @(negedge sys_clk);
        check_eq(exp_q.size(), 0, "responses still expected");
        $display("Regression passed");
        $finish;
    end

endmodule : tb_periph_soc

`default_nettype wire

// File: src.f
hdl/soc_periph_pkg.sv
hdl/periph_router.sv
hdl/gpio_regs.sv
hdl/mtimer.sv
hdl/irq_ctrl.sv
hdl/periph_soc.sv
verification/periph_soc_chk.sv
verification/tb_periph_soc.sv

// File: Makefile
TOP = tb_periph_soc

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim

run: build
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
